// File: logic/jtframe_dwnld_pkg.sv
`default_nettype none

package jtframe_dwnld_pkg;

    // SDRAM word address width
    localparam int SDRAMW     = 23;
    // Buffer slots, also the credits held by the producer at reset
    localparam int FIFO_DEPTH = 4;
    localparam int CREDIT_W   = 3;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);

    typedef logic [ 7:0] byte_t;
    typedef logic [15:0] word_t;

    // Active high, bit 0 is the even (low) byte
    typedef logic [ 1:0] mask_t;

    typedef logic [26:0]         hps_addr_t;
    typedef logic [ 7:0]         hps_index_t;
    typedef logic [SDRAMW-1:0]   prog_addr_t;
    typedef logic [CREDIT_W-1:0] credit_t;

    // Only ROM downloads are written to SDRAM
    localparam hps_index_t ROM_INDEX = 8'd0;

    typedef enum logic {
        PACK_EMPTY,
        PACK_HALF
    } pack_state_t;

    typedef enum logic {
        WR_IDLE,
        WR_BUSY
    } writer_state_t;

endpackage

`default_nettype wire

// File: logic/jtframe_dwnld_pack.sv
`default_nettype none

module jtframe_dwnld_pack(
    input  wire                                clk_rom,
    input  wire                                rst,
    input  wire                                hps_download,
    input  wire                                hps_wr,
    input  wire jtframe_dwnld_pkg::hps_addr_t  hps_addr,
    input  wire jtframe_dwnld_pkg::hps_index_t hps_index,
    input  wire jtframe_dwnld_pkg::byte_t      hps_dout,
    input  wire                                credit_return,
    output logic                               hps_wait,
    output logic                               downloading,
    output logic                               push,
    output jtframe_dwnld_pkg::prog_addr_t      push_addr,
    output jtframe_dwnld_pkg::word_t           push_data,
    output jtframe_dwnld_pkg::mask_t           push_mask
);

jtframe_dwnld_pkg::pack_state_t state, state_nx;
jtframe_dwnld_pkg::prog_addr_t  hold_addr, byte_addr, push_addr_nx;
jtframe_dwnld_pkg::byte_t       hold_byte;
jtframe_dwnld_pkg::word_t       hold_word, push_data_nx;
jtframe_dwnld_pkg::mask_t       hold_mask, push_mask_nx;
jtframe_dwnld_pkg::credit_t     credit, credit_nx;
logic                           hold_odd;
logic                           rom_wr, pair, flush_end;
logic                           push_nx, load_hold;

assign rom_wr    = hps_download && hps_wr && hps_index == jtframe_dwnld_pkg::ROM_INDEX;
assign byte_addr = hps_addr[jtframe_dwnld_pkg::SDRAMW:1];

// Odd byte completing the held even byte of the same word
assign pair = state == jtframe_dwnld_pkg::PACK_HALF && !hold_odd && hps_addr[0]
              && hold_addr == byte_addr;

// Held byte as a partial word, the missing lane stays zero
assign hold_word = hold_odd ? {hold_byte, 8'h00} : {8'h00, hold_byte};
assign hold_mask = hold_odd ? 2'b01 : 2'b10;

// Leftover byte once the download has ended
assign flush_end = !hps_download && state == jtframe_dwnld_pkg::PACK_HALF
                   && credit != '0;

always_comb begin
    state_nx     = state;
    push_nx      = 1'b0;
    load_hold    = 1'b0;
    push_addr_nx = hold_addr;
    push_data_nx = hold_word;
    push_mask_nx = hold_mask;
    if (rom_wr) begin
        if (pair) begin
            push_nx      = 1'b1;
            push_data_nx = {hps_dout, hold_byte};
            push_mask_nx = '0;
            state_nx     = jtframe_dwnld_pkg::PACK_EMPTY;
        end else begin
            // A held byte of another word leaves on its own
            push_nx   = state == jtframe_dwnld_pkg::PACK_HALF;
            load_hold = 1'b1;
            state_nx  = jtframe_dwnld_pkg::PACK_HALF;
        end
    end else if (flush_end) begin
        push_nx  = 1'b1;
        state_nx = jtframe_dwnld_pkg::PACK_EMPTY;
    end
end

// One credit per push, one back per word acknowledged by the SDRAM
always_comb begin
    credit_nx = credit;
    if (credit_return) begin
        credit_nx = credit_nx + jtframe_dwnld_pkg::credit_t'(1);
    end
    if (push_nx) begin
        credit_nx = credit_nx - jtframe_dwnld_pkg::credit_t'(1);
    end
end

always_ff @(posedge clk_rom) begin
    if (rst) begin
        state       <= jtframe_dwnld_pkg::PACK_EMPTY;
        push        <= 1'b0;
        credit      <= jtframe_dwnld_pkg::credit_t'(jtframe_dwnld_pkg::FIFO_DEPTH);
        hps_wait    <= 1'b0;
        downloading <= 1'b0;
    end else begin
        state    <= state_nx;
        push     <= push_nx;
        credit   <= credit_nx;
        // No credit left, so the HPS must hold the next byte
        hps_wait <= credit_nx == '0;
        downloading <= hps_download || state_nx == jtframe_dwnld_pkg::PACK_HALF
                       || credit_nx != jtframe_dwnld_pkg::credit_t'(jtframe_dwnld_pkg::FIFO_DEPTH);
    end
end

always_ff @(posedge clk_rom) begin
    if (load_hold) begin
        hold_addr <= byte_addr;
        hold_byte <= hps_dout;
        hold_odd  <= hps_addr[0];
    end
    if (push_nx) begin
        push_addr <= push_addr_nx;
        push_data <= push_data_nx;
        push_mask <= push_mask_nx;
    end
end

endmodule

`default_nettype wire

// File: logic/jtframe_dwnld_fifo.sv
`default_nettype none

module jtframe_dwnld_fifo(
    input  wire                                clk_rom,
    input  wire                                rst,
    input  wire                                push,
    input  wire jtframe_dwnld_pkg::prog_addr_t push_addr,
    input  wire jtframe_dwnld_pkg::word_t      push_data,
    input  wire jtframe_dwnld_pkg::mask_t      push_mask,
    input  wire                                pop,
    output logic                               word_valid,
    output jtframe_dwnld_pkg::prog_addr_t      word_addr,
    output jtframe_dwnld_pkg::word_t           word_data,
    output jtframe_dwnld_pkg::mask_t           word_mask,
    output logic                               credit_return
);

jtframe_dwnld_pkg::prog_addr_t mem_addr [jtframe_dwnld_pkg::FIFO_DEPTH];
jtframe_dwnld_pkg::word_t      mem_data [jtframe_dwnld_pkg::FIFO_DEPTH];
jtframe_dwnld_pkg::mask_t      mem_mask [jtframe_dwnld_pkg::FIFO_DEPTH];

logic [jtframe_dwnld_pkg::PTR_W-1:0] wr_ptr, rd_ptr;
jtframe_dwnld_pkg::credit_t          count;

// Head entry is always visible
assign word_valid = count != '0;
assign word_addr  = mem_addr[rd_ptr];
assign word_data  = mem_data[rd_ptr];
assign word_mask  = mem_mask[rd_ptr];

always_ff @(posedge clk_rom) begin
    if (rst) begin
        wr_ptr        <= '0;
        rd_ptr        <= '0;
        count         <= '0;
        credit_return <= 1'b0;
    end else begin
        if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({push, pop})
            2'b10:   count <= count + jtframe_dwnld_pkg::credit_t'(1);
            2'b01:   count <= count - jtframe_dwnld_pkg::credit_t'(1);
            default: count <= count;
        endcase
        // Slot freed, hand the credit back to the producer
        credit_return <= pop;
    end
end

// Storage
always_ff @(posedge clk_rom) begin
    if (push) begin
        mem_addr[wr_ptr] <= push_addr;
        mem_data[wr_ptr] <= push_data;
        mem_mask[wr_ptr] <= push_mask;
    end
end

endmodule

`default_nettype wire

// File: logic/jtframe_prog_writer.sv
`default_nettype none

module jtframe_prog_writer(
    input  wire                                clk_rom,
    input  wire                                rst,
    input  wire                                word_valid,
    input  wire jtframe_dwnld_pkg::prog_addr_t word_addr,
    input  wire jtframe_dwnld_pkg::word_t      word_data,
    input  wire jtframe_dwnld_pkg::mask_t      word_mask,
    input  wire                                prog_rdy,
    output logic                               pop,
    output logic                               prog_we,
    output jtframe_dwnld_pkg::prog_addr_t      prog_addr,
    output jtframe_dwnld_pkg::word_t           prog_data,
    output jtframe_dwnld_pkg::mask_t           prog_mask
);

jtframe_dwnld_pkg::writer_state_t state;
logic                             start;

// Take the head word when idle
assign start = state == jtframe_dwnld_pkg::WR_IDLE && word_valid;

// Write request stays up for the whole busy phase
assign prog_we = state == jtframe_dwnld_pkg::WR_BUSY;

// Head word leaves the queue once the SDRAM has taken it
assign pop = state == jtframe_dwnld_pkg::WR_BUSY && prog_rdy;

always_ff @(posedge clk_rom) begin
    if (rst) begin
        state <= jtframe_dwnld_pkg::WR_IDLE;
    end else begin
        case (state)
            jtframe_dwnld_pkg::WR_IDLE: begin
                if (word_valid) begin
                    state <= jtframe_dwnld_pkg::WR_BUSY;
                end
            end
            jtframe_dwnld_pkg::WR_BUSY: begin
                if (prog_rdy) begin
                    state <= jtframe_dwnld_pkg::WR_IDLE;
                end
            end
            default: state <= jtframe_dwnld_pkg::WR_IDLE;
        endcase
    end
end

// Program registers, steady until prog_rdy
always_ff @(posedge clk_rom) begin
    if (start) begin
        prog_addr <= word_addr;
        prog_data <= word_data;
        prog_mask <= word_mask;
    end
end

endmodule

`default_nettype wire

// File: logic/jtframe_dwnld_top.sv
`default_nettype none

module jtframe_dwnld_top(
    input  wire                                clk_rom,
    input  wire                                rst,
    // HPS download stream
    input  wire                                hps_download,
    input  wire                                hps_wr,
    input  wire jtframe_dwnld_pkg::hps_addr_t  hps_addr,
    input  wire jtframe_dwnld_pkg::hps_index_t hps_index,
    input  wire jtframe_dwnld_pkg::byte_t      hps_dout,
    output logic                               hps_wait,
    output logic                               downloading,
    // SDRAM programming port
    output logic                               prog_we,
    output jtframe_dwnld_pkg::prog_addr_t      prog_addr,
    output jtframe_dwnld_pkg::word_t           prog_data,
    output jtframe_dwnld_pkg::mask_t           prog_mask,
    input  wire                                prog_rdy
);

logic                          push, pop, credit_return, word_valid;
jtframe_dwnld_pkg::prog_addr_t push_addr, word_addr;
jtframe_dwnld_pkg::word_t      push_data, word_data;
jtframe_dwnld_pkg::mask_t      push_mask, word_mask;

jtframe_dwnld_pack u_pack(
    .clk_rom        ( clk_rom        ),
    .rst            ( rst            ),
    .hps_download   ( hps_download   ),
    .hps_wr         ( hps_wr         ),
    .hps_addr       ( hps_addr       ),
    .hps_index      ( hps_index      ),
    .hps_dout       ( hps_dout       ),
    .credit_return  ( credit_return  ),
    .hps_wait       ( hps_wait       ),
    .downloading    ( downloading    ),
    .push           ( push           ),
    .push_addr      ( push_addr      ),
    .push_data      ( push_data      ),
    .push_mask      ( push_mask      )
);

jtframe_dwnld_fifo u_fifo(
    .clk_rom        ( clk_rom        ),
    .rst            ( rst            ),
    .push           ( push           ),
    .push_addr      ( push_addr      ),
    .push_data      ( push_data      ),
    .push_mask      ( push_mask      ),
    .pop            ( pop            ),
    .word_valid     ( word_valid     ),
    .word_addr      ( word_addr      ),
    .word_data      ( word_data      ),
    .word_mask      ( word_mask      ),
    .credit_return  ( credit_return  )
);

jtframe_prog_writer u_writer(
    .clk_rom        ( clk_rom        ),
    .rst            ( rst            ),
    .word_valid     ( word_valid     ),
    .word_addr      ( word_addr      ),
    .word_data      ( word_data      ),
    .word_mask      ( word_mask      ),
    .prog_rdy       ( prog_rdy       ),
    .pop            ( pop            ),
    .prog_we        ( prog_we        ),
    .prog_addr      ( prog_addr      ),
    .prog_data      ( prog_data      ),
    .prog_mask      ( prog_mask      )
);

endmodule

`default_nettype wire

// File: tb/tb_sdram_model.sv
`default_nettype none

module tb_sdram_model(
    input  wire                                clk,
    input  wire                                rst,
    input  wire [7:0]                          max_delay,
    input  wire                                prog_we,
    input  wire jtframe_dwnld_pkg::prog_addr_t prog_addr,
    input  wire jtframe_dwnld_pkg::word_t      prog_data,
    input  wire jtframe_dwnld_pkg::mask_t      prog_mask,
    output logic                               prog_rdy
);

timeunit 1ns;
timeprecision 1ns;

// Accepted writes in arrival order
jtframe_dwnld_pkg::prog_addr_t q_addr [$];
jtframe_dwnld_pkg::word_t      q_data [$];
jtframe_dwnld_pkg::mask_t      q_mask [$];
int   bytes_done;
int   seed;
int   wait_cnt;
logic busy;

initial begin
    prog_rdy   = 1'b0;
    busy       = 1'b0;
    wait_cnt   = 0;
    bytes_done = 0;
    seed       = 19246;
end

// A write counts as taken on the rising edge that sees prog_rdy
always @(posedge clk) begin
    if (!rst && prog_rdy) begin
        q_addr.push_back(prog_addr);
        q_data.push_back(prog_data);
        q_mask.push_back(prog_mask);
        bytes_done = bytes_done + 2 - int'(prog_mask[0]) - int'(prog_mask[1]);
    end
end

// Random latency of 1 to max_delay cycles per write
always @(negedge clk) begin
    if (rst || prog_rdy) begin
        prog_rdy = 1'b0;
        busy     = 1'b0;
    end else if (prog_we) begin
        if (!busy) begin
            busy     = 1'b1;
            wait_cnt = $unsigned($random(seed)) % max_delay;
        end else begin
            wait_cnt = wait_cnt - 1;
        end
        prog_rdy = wait_cnt == 0;
    end
end

endmodule

`default_nettype wire

// File: tb/tb_dwnld.sv
`default_nettype none

module tb_dwnld;

timeunit 1ns;
timeprecision 1ns;

localparam int TIMEOUT = 2000;

logic                          clk, rst;
logic                          hps_download, hps_wr;
jtframe_dwnld_pkg::hps_addr_t  hps_addr;
jtframe_dwnld_pkg::hps_index_t hps_index;
jtframe_dwnld_pkg::byte_t      hps_dout;
logic                          hps_wait, downloading, prog_we, prog_rdy;
jtframe_dwnld_pkg::prog_addr_t prog_addr;
jtframe_dwnld_pkg::word_t      prog_data;
jtframe_dwnld_pkg::mask_t      prog_mask;
logic [7:0]                    mem_delay;

int   errors, timeouts, rom_bytes;
logic saw_wait;
jtframe_dwnld_pkg::prog_addr_t exp_addr [$];
jtframe_dwnld_pkg::word_t      exp_data [$];
jtframe_dwnld_pkg::mask_t      exp_mask [$];

jtframe_dwnld_top i_dut(
    .clk_rom(clk), .rst(rst), .hps_download(hps_download), .hps_wr(hps_wr),
    .hps_addr(hps_addr), .hps_index(hps_index), .hps_dout(hps_dout),
    .hps_wait(hps_wait), .downloading(downloading), .prog_we(prog_we),
    .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
    .prog_rdy(prog_rdy)
);

tb_sdram_model u_mem(
    .clk(clk), .rst(rst), .max_delay(mem_delay), .prog_we(prog_we),
    .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
    .prog_rdy(prog_rdy)
);

always #50 clk = ~clk;

always @(posedge clk) begin
    if (hps_wait) saw_wait = 1'b1;
end

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Error: %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

// Data lanes marked as not written are left out of the data compare
task automatic check_word(
    input jtframe_dwnld_pkg::prog_addr_t got_addr, exp_addr,
    input jtframe_dwnld_pkg::word_t      got_data, exp_data,
    input jtframe_dwnld_pkg::mask_t      got_mask, exp_mask
);
    jtframe_dwnld_pkg::word_t keep;
    keep = {{8{~exp_mask[1]}}, {8{~exp_mask[0]}}};
    if (got_addr !== exp_addr) begin
        $display("Error: prog_addr got %h expected %h", got_addr, exp_addr);
        errors++;
    end
    if ((got_data & keep) !== (exp_data & keep)) begin
        $display("Error: prog_data got %h expected %h", got_data, exp_data);
        errors++;
    end
    if (got_mask !== exp_mask) begin
        $display("Error: prog_mask got %h expected %h", got_mask, exp_mask);
        errors++;
    end
endtask

task automatic send_byte(
    input jtframe_dwnld_pkg::hps_index_t index,
    input jtframe_dwnld_pkg::hps_addr_t  addr,
    input jtframe_dwnld_pkg::byte_t      data
);
    int n;
    if (!hps_download) begin
        hps_download = 1'b1;
        @(negedge clk);
    end
    n = 0;
    while (hps_wait && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (hps_wait) begin
        $display("Timeout: hps_wait never dropped for the byte at %h", addr);
        timeouts++;
    end else begin
        hps_wr    = 1'b1;
        hps_index = index;
        hps_addr  = addr;
        hps_dout  = data;
        if (index == jtframe_dwnld_pkg::ROM_INDEX) rom_bytes++;
        if (rom_bytes - u_mem.bytes_done > 2 * (jtframe_dwnld_pkg::FIFO_DEPTH + 1)) begin
            $display("Too many words in flight, %0d bytes not yet written",
                     rom_bytes - u_mem.bytes_done);
            errors++;
        end
        @(negedge clk);
        hps_wr = 1'b0;
    end
endtask

// Drop hps_download, wait for all writes and compare them in order
task automatic finish_download;
    int n;
    hps_download = 1'b0;
    n = 0;
    while (u_mem.q_addr.size() < exp_addr.size() && n < TIMEOUT) begin
        check_flag("downloading", downloading, 1'b1);
        @(negedge clk);
        n++;
    end
    if (u_mem.q_addr.size() < exp_addr.size()) begin
        $display("Timeout: only %0d of %0d writes arrived",
                 u_mem.q_addr.size(), exp_addr.size());
        timeouts++;
    end
    n = 0;
    while (downloading && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (downloading) begin
        $display("Timeout: downloading stayed high after the last write");
        timeouts++;
    end
    if (u_mem.q_addr.size() > exp_addr.size()) begin
        $display("The memory got %0d writes where %0d were expected",
                 u_mem.q_addr.size(), exp_addr.size());
        errors++;
    end
    while (exp_addr.size() > 0 && u_mem.q_addr.size() > 0) begin
        check_word(u_mem.q_addr.pop_front(), exp_addr.pop_front(),
                   u_mem.q_data.pop_front(), exp_data.pop_front(),
                   u_mem.q_mask.pop_front(), exp_mask.pop_front());
    end
    exp_addr.delete();
    exp_data.delete();
    exp_mask.delete();
    u_mem.q_addr.delete();
    u_mem.q_data.delete();
    u_mem.q_mask.delete();
endtask

initial begin
    int          fd, code;
    string       line, rest;
    logic [7:0]  kind;
    logic [31:0] f1, f2, f3;
    errors       = 0;
    timeouts     = 0;
    rom_bytes    = 0;
    saw_wait     = 1'b0;
    clk          = 1'b0;
    rst          = 1'b1;
    hps_download = 1'b0;
    hps_wr       = 1'b0;
    hps_addr     = '0;
    hps_index    = '0;
    hps_dout     = '0;
    mem_delay    = 8'd1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_flag("prog_we", prog_we, 1'b0);
    check_flag("hps_wait", hps_wait, 1'b0);
    check_flag("downloading", downloading, 1'b0);
    fd = $fopen("tb/dwnld_cases.txt", "r");
    if (fd == 0) begin
        $display("The case file tb/dwnld_cases.txt could not be opened");
        errors++;
    end else begin
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0) begin
                kind = line.getc(0);
                rest = line.substr(1, line.len() - 1);
                case (kind)
                    "s": begin
                        code      = $sscanf(rest, "%h", f1);
                        mem_delay = f1[7:0];
                        saw_wait  = 1'b0;
                    end
                    "b": begin
                        code = $sscanf(rest, "%h %h %h", f1, f2, f3);
                        send_byte(jtframe_dwnld_pkg::hps_index_t'(f1),
                                  jtframe_dwnld_pkg::hps_addr_t'(f2),
                                  jtframe_dwnld_pkg::byte_t'(f3));
                    end
                    "w": begin
                        code = $sscanf(rest, "%h %h %h", f1, f2, f3);
                        exp_addr.push_back(jtframe_dwnld_pkg::prog_addr_t'(f1));
                        exp_data.push_back(jtframe_dwnld_pkg::word_t'(f2));
                        exp_mask.push_back(jtframe_dwnld_pkg::mask_t'(f3));
                    end
                    "h": check_flag("hps_wait seen", saw_wait, 1'b1);
                    "e": finish_download();
                    default: ;
                endcase
            end
        end
        $fclose(fd);
    end
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: tb/dwnld_cases.txt
# b index addr data | w word_addr data mask | s max prog_rdy delay
# e end of download | h hps_wait must have risen since the last s
s 1
b 0 0000000 11
b 0 0000001 22
b 0 0000002 33
b 0 0000003 44
w 000000 2211 0
w 000001 4433 0
# odd start address
b 0 0000011 55
b 0 0000012 66
b 0 0000013 77
w 000008 5500 1
w 000009 7766 0
# gap, with a foreign index byte in between
b 0 0000020 88
b 0 0000030 99
b 1 0000031 aa
b 0 0000031 bb
w 000010 0088 2
w 000018 bb99 0
# even byte left over at the end
b 0 0000040 cc
w 000020 00cc 2
e
# foreign index only
b 2 0000050 dd
b 2 0000051 ee
e
# slow memory
s 8
b 0 0000100 01
b 0 0000101 02
b 0 0000102 03
b 0 0000103 04
b 0 0000104 05
b 0 0000105 06
b 0 0000106 07
b 0 0000107 08
b 0 0000108 09
b 0 0000109 0a
b 0 000010a 0b
w 000080 0201 0
w 000081 0403 0
w 000082 0605 0
w 000083 0807 0
w 000084 0a09 0
w 000085 000b 2
h
e

// File: sources.f
logic/jtframe_dwnld_pkg.sv
logic/jtframe_dwnld_pack.sv
logic/jtframe_dwnld_fifo.sv
logic/jtframe_prog_writer.sv
logic/jtframe_dwnld_top.sv
tb/tb_sdram_model.sv
tb/tb_dwnld.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_dwnld -o tb_dwnld

run: compile
	./obj_dir/tb_dwnld | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
